//--- hart_cfg_pkg.sv
package hart_cfg_pkg;

  // datapath width
  localparam int XLEN = 32;

  // five address bits select one of 32 architectural registers
  localparam int REG_ADDR_W = 5;

  // instruction queue size and its pointer width
  localparam int QUEUE_DEPTH = 2;
  localparam int QUEUE_PTR_W = 1;

  // first fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;

endpackage

//--- rv_isa_pkg.sv
package rv_isa_pkg;

  // major opcodes of the RV32I subset this hart understands
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011,
    SYSTEM = 7'b1110011
  } opcode_e;

  // internal ALU operations, decoded from funct3 and funct7
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  // lowest bit of each instruction field
  localparam int OPCODE_LSB = 0;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_LSB = 25;

  // funct7 with bit 30 set picks sub over add and sra over srl
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  // funct3 values shared by the register and immediate ALU forms
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // the two branch conditions that are kept
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // ebreak is the only SYSTEM word accepted; it halts the hart
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

endpackage

//--- fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic                         i_clk,
  input  logic                         i_rst,
  input  logic                         i_imem_ready,
  input  logic                         i_imem_valid,
  input  logic [hart_cfg_pkg::XLEN-1:0] i_imem_rdata,
  input  logic                         i_queue_full,
  input  logic                         i_redirect,
  input  logic [hart_cfg_pkg::XLEN-1:0] i_redirect_pc,
  output logic                         o_imem_ren,
  output logic [hart_cfg_pkg::XLEN-1:0] o_imem_raddr,
  output logic                         o_push,
  output logic [hart_cfg_pkg::XLEN-1:0] o_push_inst,
  output logic [hart_cfg_pkg::XLEN-1:0] o_push_pc
);

  // next address to request from instruction memory
  logic [hart_cfg_pkg::XLEN-1:0] pc_q;
  // set while a request has been accepted and its response is still due
  logic                          outstanding_q;
  // address and epoch of the request in flight
  logic [hart_cfg_pkg::XLEN-1:0] req_pc_q;
  logic                          req_epoch_q;
  // flips on every redirect so that stale responses can be spotted
  logic                          epoch_q;
  logic                          req_accept;

  // only one request may be in flight, and a free queue slot is kept for it
  // a redirect pulls the request back so the old address is never sent
  // no request goes out while reset is held
  assign o_imem_ren   = !i_rst && !outstanding_q && !i_queue_full && !i_redirect;
  assign o_imem_raddr = pc_q;
  assign req_accept   = o_imem_ren && i_imem_ready;

  // the response is forwarded only if no redirect happened since it was asked for
  assign o_push      = i_imem_valid && outstanding_q && (req_epoch_q == epoch_q);
  assign o_push_inst = i_imem_rdata;
  assign o_push_pc   = req_pc_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q          <= hart_cfg_pkg::RESET_PC;
      outstanding_q <= 1'b0;
      epoch_q       <= 1'b0;
    end else begin
      // a taken branch restarts fetch at its target
      if (i_redirect) begin
        pc_q    <= i_redirect_pc;
        epoch_q <= !epoch_q;
      end else if (req_accept) begin
        pc_q <= pc_q + hart_cfg_pkg::XLEN'(4);
      end
      // accept and response never share a cycle, since accept needs an idle port
      if (req_accept) begin
        outstanding_q <= 1'b1;
      end else if (i_imem_valid) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  // capture the address and epoch of each accepted request
  always_ff @(posedge i_clk) begin
    if (req_accept) begin
      req_pc_q    <= pc_q;
      req_epoch_q <= epoch_q;
    end
  end

endmodule

//--- inst_queue.sv
`timescale 1ns/1ps

module inst_queue (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic                          i_push,
  input  logic [hart_cfg_pkg::XLEN-1:0] i_push_inst,
  input  logic [hart_cfg_pkg::XLEN-1:0] i_push_pc,
  input  logic                          i_pop,
  input  logic                          i_flush,
  output logic [hart_cfg_pkg::XLEN-1:0] o_head_inst,
  output logic [hart_cfg_pkg::XLEN-1:0] o_head_pc,
  output logic                          o_empty,
  output logic                          o_full
);

  // instruction words and the addresses they came from
  logic [hart_cfg_pkg::XLEN-1:0] inst_mem [hart_cfg_pkg::QUEUE_DEPTH];
  logic [hart_cfg_pkg::XLEN-1:0] pc_mem   [hart_cfg_pkg::QUEUE_DEPTH];
  logic [hart_cfg_pkg::QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [hart_cfg_pkg::QUEUE_PTR_W-1:0] rd_ptr_q;
  // one extra bit so a full queue can be told apart from an empty one
  logic [hart_cfg_pkg::QUEUE_PTR_W:0]   count_q;
  logic                                 do_push;
  logic                                 do_pop;

  assign o_empty = (count_q == '0);
  assign o_full  = (count_q == (hart_cfg_pkg::QUEUE_PTR_W + 1)'(hart_cfg_pkg::QUEUE_DEPTH));

  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;

  assign o_head_inst = inst_mem[rd_ptr_q];
  assign o_head_pc   = pc_mem[rd_ptr_q];

  always_ff @(posedge i_clk) begin
    if (i_rst || i_flush) begin
      // a flush also drops a word pushed on the same edge
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // push and pop together leave the count as it is
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      inst_mem[wr_ptr_q] <= i_push_inst;
      pc_mem[wr_ptr_q]   <= i_push_pc;
    end
  end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  logic [hart_cfg_pkg::REG_ADDR_W-1:0] i_rs1_addr,
  input  logic [hart_cfg_pkg::REG_ADDR_W-1:0] i_rs2_addr,
  input  logic                                i_rd_wen,
  input  logic [hart_cfg_pkg::REG_ADDR_W-1:0] i_rd_addr,
  input  logic [hart_cfg_pkg::XLEN-1:0]       i_rd_wdata,
  output logic [hart_cfg_pkg::XLEN-1:0]       o_rs1_data,
  output logic [hart_cfg_pkg::XLEN-1:0]       o_rs2_data
);

  // x0 has no storage, so only x1 to x31 exist here
  logic [hart_cfg_pkg::XLEN-1:0] regs [1:2**hart_cfg_pkg::REG_ADDR_W-1];

  // reads are combinational so execute sees its operands in the pop cycle
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 2**hart_cfg_pkg::REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && (i_rd_addr != '0)) begin
      // writes to x0 fall through here and are lost
      regs[i_rd_addr] <= i_rd_wdata;
    end
  end

endmodule

//--- exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  logic [hart_cfg_pkg::XLEN-1:0]       i_head_inst,
  input  logic [hart_cfg_pkg::XLEN-1:0]       i_head_pc,
  input  logic                                i_empty,
  input  logic [hart_cfg_pkg::XLEN-1:0]       i_rs1_data,
  input  logic [hart_cfg_pkg::XLEN-1:0]       i_rs2_data,
  output logic                                o_pop,
  output logic                                o_redirect,
  output logic [hart_cfg_pkg::XLEN-1:0]       o_redirect_pc,
  output logic [hart_cfg_pkg::REG_ADDR_W-1:0] o_rs1_addr,
  output logic [hart_cfg_pkg::REG_ADDR_W-1:0] o_rs2_addr,
  output logic                                o_rd_wen,
  output logic [hart_cfg_pkg::REG_ADDR_W-1:0] o_rd_addr,
  output logic [hart_cfg_pkg::XLEN-1:0]       o_rd_wdata,
  output logic                                o_retire_valid,
  output logic [hart_cfg_pkg::XLEN-1:0]       o_retire_inst,
  output logic [hart_cfg_pkg::XLEN-1:0]       o_retire_pc,
  output logic [hart_cfg_pkg::XLEN-1:0]       o_retire_next_pc,
  output logic [hart_cfg_pkg::REG_ADDR_W-1:0] o_retire_rd_waddr,
  output logic [hart_cfg_pkg::XLEN-1:0]       o_retire_rd_wdata,
  output logic                                o_retire_trap,
  output logic                                o_retire_halt
);

  rv_isa_pkg::opcode_e           opcode;
  rv_isa_pkg::alu_op_e           alu_op;
  logic [2:0]                    funct3;
  logic [6:0]                    funct7;
  logic [hart_cfg_pkg::XLEN-1:0] imm_i;
  logic [hart_cfg_pkg::XLEN-1:0] imm_b;
  logic [hart_cfg_pkg::XLEN-1:0] imm_u;
  logic [hart_cfg_pkg::XLEN-1:0] operand_b;
  logic [hart_cfg_pkg::XLEN-1:0] alu_result;
  logic [hart_cfg_pkg::XLEN-1:0] result;
  logic [hart_cfg_pkg::XLEN-1:0] next_pc;
  logic legal;
  logic writes_rd;
  logic is_halt;
  logic taken;
  // stays set after ebreak until the next reset
  logic halted_q;

  assign opcode     = rv_isa_pkg::opcode_e'(i_head_inst[rv_isa_pkg::OPCODE_LSB +: 7]);
  assign funct3     = i_head_inst[rv_isa_pkg::FUNCT3_LSB +: 3];
  assign funct7     = i_head_inst[rv_isa_pkg::FUNCT7_LSB +: 7];
  assign o_rs1_addr = i_head_inst[rv_isa_pkg::RS1_LSB +: hart_cfg_pkg::REG_ADDR_W];
  assign o_rs2_addr = i_head_inst[rv_isa_pkg::RS2_LSB +: hart_cfg_pkg::REG_ADDR_W];
  assign o_rd_addr  = i_head_inst[rv_isa_pkg::RD_LSB +: hart_cfg_pkg::REG_ADDR_W];

  assign imm_i = {{20{i_head_inst[31]}}, i_head_inst[31:20]};
  assign imm_b = {{20{i_head_inst[31]}}, i_head_inst[7], i_head_inst[30:25],
                  i_head_inst[11:8], 1'b0};
  assign imm_u = {i_head_inst[31:12], 12'b0};

  always_comb begin
    // the alternate funct7 only means something for register-register ops
    case (funct3)
      rv_isa_pkg::F3_SLL:  alu_op = rv_isa_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:  alu_op = rv_isa_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU: alu_op = rv_isa_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:  alu_op = rv_isa_pkg::ALU_XOR;
      rv_isa_pkg::F3_OR:   alu_op = rv_isa_pkg::ALU_OR;
      rv_isa_pkg::F3_AND:  alu_op = rv_isa_pkg::ALU_AND;
      rv_isa_pkg::F3_SRL_SRA: begin
        alu_op = (funct7 == rv_isa_pkg::FUNCT7_ALT) ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      end
      default: begin
        alu_op = (opcode == rv_isa_pkg::OP && funct7 == rv_isa_pkg::FUNCT7_ALT) ?
                 rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
      end
    endcase
  end

  always_comb begin
    // anything not matched below retires as a trap
    legal     = 1'b0;
    writes_rd = 1'b0;
    is_halt   = 1'b0;
    case (opcode)
      rv_isa_pkg::OP: begin
        legal = (funct7 == '0) || (funct7 == rv_isa_pkg::FUNCT7_ALT &&
                (funct3 == rv_isa_pkg::F3_ADD_SUB || funct3 == rv_isa_pkg::F3_SRL_SRA));
        writes_rd = legal;
      end
      rv_isa_pkg::OP_IMM: begin
        // immediate shifts are not part of the kept subset
        legal     = (funct3 != rv_isa_pkg::F3_SLL) && (funct3 != rv_isa_pkg::F3_SRL_SRA);
        writes_rd = legal;
      end
      rv_isa_pkg::LUI: begin
        legal     = 1'b1;
        writes_rd = 1'b1;
      end
      rv_isa_pkg::BRANCH: legal = (funct3 == rv_isa_pkg::F3_BEQ) || (funct3 == rv_isa_pkg::F3_BNE);
      rv_isa_pkg::SYSTEM: begin
        is_halt = (i_head_inst == rv_isa_pkg::EBREAK_WORD);
        legal   = is_halt;
      end
      default: legal = 1'b0;
    endcase
  end

  assign operand_b = (opcode == rv_isa_pkg::OP_IMM) ? imm_i : i_rs2_data;

  always_comb begin
    case (alu_op)
      rv_isa_pkg::ALU_SUB:  alu_result = i_rs1_data - operand_b;
      rv_isa_pkg::ALU_AND:  alu_result = i_rs1_data & operand_b;
      rv_isa_pkg::ALU_OR:   alu_result = i_rs1_data | operand_b;
      rv_isa_pkg::ALU_XOR:  alu_result = i_rs1_data ^ operand_b;
      rv_isa_pkg::ALU_SLT:  alu_result = {31'b0, $signed(i_rs1_data) < $signed(operand_b)};
      rv_isa_pkg::ALU_SLTU: alu_result = {31'b0, i_rs1_data < operand_b};
      rv_isa_pkg::ALU_SLL:  alu_result = i_rs1_data << operand_b[4:0];
      rv_isa_pkg::ALU_SRL:  alu_result = i_rs1_data >> operand_b[4:0];
      rv_isa_pkg::ALU_SRA:  alu_result = $signed(i_rs1_data) >>> operand_b[4:0];
      default:              alu_result = i_rs1_data + operand_b;
    endcase
  end

  assign result = (opcode == rv_isa_pkg::LUI) ? imm_u : alu_result;

  // beq takes on equal operands, bne on unequal ones
  assign taken   = legal && (opcode == rv_isa_pkg::BRANCH) &&
                   ((i_rs1_data == i_rs2_data) == (funct3 == rv_isa_pkg::F3_BEQ));
  assign next_pc = taken ? i_head_pc + imm_b : i_head_pc + hart_cfg_pkg::XLEN'(4);

  assign o_pop         = !i_empty && !halted_q;
  assign o_redirect    = o_pop && taken;
  assign o_redirect_pc = next_pc;
  // the register file writes on the same edge that pops the word
  assign o_rd_wen      = o_pop && writes_rd && (o_rd_addr != '0);
  assign o_rd_wdata    = result;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      halted_q       <= 1'b0;
      o_retire_valid <= 1'b0;
    end else begin
      o_retire_valid <= o_pop;
      if (o_pop && is_halt) begin
        halted_q <= 1'b1;
      end
    end
  end

  // retire record of the popped word, shown one cycle after the pop
  always_ff @(posedge i_clk) begin
    if (o_pop) begin
      o_retire_inst     <= i_head_inst;
      o_retire_pc       <= i_head_pc;
      o_retire_next_pc  <= next_pc;
      o_retire_rd_waddr <= o_rd_wen ? o_rd_addr : '0;
      o_retire_rd_wdata <= o_rd_wen ? result : '0;
      o_retire_trap     <= !legal;
      o_retire_halt     <= is_halt;
    end
  end

endmodule

//--- hart.sv
`timescale 1ns/1ps

module hart (
  input  logic                                i_clk,
  input  logic                                i_rst,
  input  logic                                i_imem_ready,
  input  logic                                i_imem_valid,
  input  logic [hart_cfg_pkg::XLEN-1:0]       i_imem_rdata,
  output logic                                o_imem_ren,
  output logic [hart_cfg_pkg::XLEN-1:0]       o_imem_raddr,
  output logic                                o_retire_valid,
  output logic [hart_cfg_pkg::XLEN-1:0]       o_retire_inst,
  output logic [hart_cfg_pkg::XLEN-1:0]       o_retire_pc,
  output logic [hart_cfg_pkg::XLEN-1:0]       o_retire_next_pc,
  output logic [hart_cfg_pkg::REG_ADDR_W-1:0] o_retire_rd_waddr,
  output logic [hart_cfg_pkg::XLEN-1:0]       o_retire_rd_wdata,
  output logic                                o_retire_trap,
  output logic                                o_retire_halt
);

  // fetch to queue
  logic                                push;
  logic [hart_cfg_pkg::XLEN-1:0]       push_inst;
  logic [hart_cfg_pkg::XLEN-1:0]       push_pc;
  logic                                queue_full;
  // queue to execute
  logic [hart_cfg_pkg::XLEN-1:0]       head_inst;
  logic [hart_cfg_pkg::XLEN-1:0]       head_pc;
  logic                                queue_empty;
  logic                                pop;
  // a taken branch flushes the queue and restarts fetch
  logic                                redirect;
  logic [hart_cfg_pkg::XLEN-1:0]       redirect_pc;
  // execute to register file
  logic [hart_cfg_pkg::REG_ADDR_W-1:0] rs1_addr;
  logic [hart_cfg_pkg::REG_ADDR_W-1:0] rs2_addr;
  logic [hart_cfg_pkg::XLEN-1:0]       rs1_data;
  logic [hart_cfg_pkg::XLEN-1:0]       rs2_data;
  logic                                rd_wen;
  logic [hart_cfg_pkg::REG_ADDR_W-1:0] rd_addr;
  logic [hart_cfg_pkg::XLEN-1:0]       rd_wdata;

  fetch_unit i_fetch_unit (
    .i_clk, .i_rst, .i_imem_ready, .i_imem_valid, .i_imem_rdata,
    .i_queue_full(queue_full), .i_redirect(redirect), .i_redirect_pc(redirect_pc),
    .o_imem_ren, .o_imem_raddr,
    .o_push(push), .o_push_inst(push_inst), .o_push_pc(push_pc)
  );

  inst_queue i_inst_queue (
    .i_clk, .i_rst, .i_push(push), .i_push_inst(push_inst), .i_push_pc(push_pc),
    .i_pop(pop), .i_flush(redirect), .o_head_inst(head_inst), .o_head_pc(head_pc),
    .o_empty(queue_empty), .o_full(queue_full)
  );

  reg_file i_reg_file (
    .i_clk, .i_rst, .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
    .i_rd_wen(rd_wen), .i_rd_addr(rd_addr), .i_rd_wdata(rd_wdata),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
  );

  exec_unit i_exec_unit (
    .i_clk, .i_rst, .i_head_inst(head_inst), .i_head_pc(head_pc), .i_empty(queue_empty),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .o_pop(pop), .o_redirect(redirect), .o_redirect_pc(redirect_pc),
    .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr),
    .o_rd_wen(rd_wen), .o_rd_addr(rd_addr), .o_rd_wdata(rd_wdata),
    .o_retire_valid, .o_retire_inst, .o_retire_pc, .o_retire_next_pc,
    .o_retire_rd_waddr, .o_retire_rd_wdata, .o_retire_trap, .o_retire_halt
  );

endmodule

//--- tb_hart.sv
`timescale 1ns/1ps

module tb_hart;

  localparam int PROG_LEN     = 200;
  localparam int HALT_TIMEOUT = 20000;
  localparam int HALT_WINDOW  = 200;

  logic                                i_clk = 1'b0;
  logic                                i_rst = 1'b1;
  logic                                i_imem_ready = 1'b0;
  logic                                i_imem_valid = 1'b0;
  logic [hart_cfg_pkg::XLEN-1:0]       i_imem_rdata = '0;
  logic                                o_imem_ren;
  logic [hart_cfg_pkg::XLEN-1:0]       o_imem_raddr;
  logic                                o_retire_valid;
  logic [hart_cfg_pkg::XLEN-1:0]       o_retire_inst;
  logic [hart_cfg_pkg::XLEN-1:0]       o_retire_pc;
  logic [hart_cfg_pkg::XLEN-1:0]       o_retire_next_pc;
  logic [hart_cfg_pkg::REG_ADDR_W-1:0] o_retire_rd_waddr;
  logic [hart_cfg_pkg::XLEN-1:0]       o_retire_rd_wdata;
  logic                                o_retire_trap;
  logic                                o_retire_halt;

  // program image and the reference model's architectural registers
  logic [31:0] prog [PROG_LEN];
  logic [31:0] mregs [32];
  // the cycle in which the latest response to each word address was valid
  int          resp_cyc [256];
  int          cyc = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          cat_err [6] = '{default: 0};
  string       cat_name [6] = '{"reset", "alu and lui", "branches", "retire stream",
                                "illegal words", "ebreak halt"};
  // the memory model keeps a single response in flight
  logic        resp_pending = 1'b0;
  int          resp_wait = 0;
  logic [31:0] resp_addr = '0;
  logic [31:0] resp_data = '0;
  logic [31:0] model_pc = hart_cfg_pkg::RESET_PC;
  int          retired = 0;
  int          rst_edges = 0;
  logic        halt_seen = 1'b0;
  int          halt_cyc = 0;
  logic        timed_out = 1'b0;

  hart i_hart (.*);

  always #2 i_clk = ~i_clk;

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp,
                       input int cat);
    if (got !== exp) begin
      $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
      fail_cnt++;
      cat_err[cat]++;
    end else begin
      pass_cnt++;
    end
  endtask

  // everything past the program reads as a nop
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    if (addr[31:2] < PROG_LEN) begin
      return prog[addr[31:2]];
    end
    return hart_cfg_pkg::NOP_WORD;
  endfunction

  function automatic logic [31:0] gen_word(input int idx);
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    int         kind;
    // a small register window makes equal operands and reuse common
    rd   = 5'($urandom_range(0, 7));
    rs1  = 5'($urandom_range(0, 7));
    rs2  = 5'($urandom_range(0, 7));
    f3   = 3'($urandom_range(0, 7));
    kind = $urandom_range(0, 19);
    f7   = 7'd0;
    if (idx == PROG_LEN - 1) begin
      return rv_isa_pkg::EBREAK_WORD;
    end else if (kind < 7) begin
      // only add and srl have an alternate form, sub and sra
      if ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) begin
        f7 = rv_isa_pkg::FUNCT7_ALT;
      end
      return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP};
    end else if (kind < 12) begin
      // immediate shifts are outside the subset
      if (f3 == 3'd1 || f3 == 3'd5) begin
        f3 = 3'd7;
      end
      return {12'($urandom), rs1, f3, rd, rv_isa_pkg::OP_IMM};
    end else if (kind < 14 || kind == 18) begin
      return {20'($urandom), rd, rv_isa_pkg::LUI};
    end else if (kind < 18 && idx <= PROG_LEN - 4) begin
      // imm[4:1] of 4 or 6 gives a forward offset of 8 or 12 that stays in the program
      return {7'd0, rs2, rs1, 2'b00, f3[0], ($urandom_range(0, 1) == 1) ? 4'd6 : 4'd4,
              1'b0, rv_isa_pkg::BRANCH};
    end else if (kind == 19) begin
      // lw has no place in this hart and must trap
      return {12'($urandom), rs1, 3'b010, rd, 7'b0000011};
    end
    return {12'($urandom), rs1, 3'b000, rd, rv_isa_pkg::OP_IMM};
  endfunction

  function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                      input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'd0, sa < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return sa >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // one RV32I step of the word at pc on the model registers
  task automatic model_step(input logic [31:0] w, input logic [31:0] pc,
                            output logic [31:0] nxt, output logic [4:0] rd,
                            output logic [31:0] wd, output logic trap, output logic halt);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [2:0]  f3;
    logic        wr;
    a    = mregs[w[19:15]];
    b    = mregs[w[24:20]];
    f3   = w[14:12];
    nxt  = pc + 32'd4;
    res  = '0;
    wr   = 1'b0;
    halt = 1'b0;
    trap = 1'b0;
    case (w[6:0])
      rv_isa_pkg::OP: begin
        wr   = (w[31:25] == 7'd0) ||
               (w[31:25] == rv_isa_pkg::FUNCT7_ALT && (f3 == 3'd0 || f3 == 3'd5));
        trap = !wr;
        res  = alu(f3, w[30], a, b);
      end
      rv_isa_pkg::OP_IMM: begin
        wr   = (f3 != 3'd1) && (f3 != 3'd5);
        trap = !wr;
        res  = alu(f3, 1'b0, a, {{20{w[31]}}, w[31:20]});
      end
      rv_isa_pkg::LUI: begin
        wr  = 1'b1;
        res = {w[31:12], 12'd0};
      end
      rv_isa_pkg::BRANCH: begin
        trap = (f3 != 3'd0) && (f3 != 3'd1);
        if (!trap && (f3 == 3'd0 ? a == b : a != b)) begin
          nxt = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      rv_isa_pkg::SYSTEM: begin
        halt = (w == rv_isa_pkg::EBREAK_WORD);
        trap = !halt;
      end
      default: trap = 1'b1;
    endcase
    // a write to x0 is reported as no write at all
    if (w[11:7] == 5'd0) begin
      wr = 1'b0;
    end
    rd = wr ? w[11:7] : 5'd0;
    wd = wr ? res : '0;
    if (wr) begin
      mregs[w[11:7]] = res;
    end
  endtask

  task automatic retire_check();
    logic [31:0] word;
    logic [31:0] exp_next;
    logic [31:0] exp_wd;
    logic [4:0]  exp_rd;
    logic        exp_trap;
    logic        exp_halt;
    int          cat;
    word = mem_word(model_pc);
    model_step(word, model_pc, exp_next, exp_rd, exp_wd, exp_trap, exp_halt);
    case (word[6:0])
      rv_isa_pkg::OP, rv_isa_pkg::OP_IMM, rv_isa_pkg::LUI: cat = 1;
      rv_isa_pkg::BRANCH: cat = 2;
      rv_isa_pkg::SYSTEM: cat = 5;
      default: cat = 4;
    endcase
    if (retired == 0) begin
      check("first retired pc", o_retire_pc, hart_cfg_pkg::RESET_PC, 0);
      $display("test %s: %s", cat_name[0], (cat_err[0] == 0) ? "pass" : "fail");
    end
    // a lost, repeated or discarded word shows up as a wrong pc here
    check("retired pc", o_retire_pc, model_pc, 3);
    check("retired word", o_retire_inst, word, 3);
    check("retire latency", 32'((cyc - resp_cyc[model_pc[9:2]]) >= 2), 32'd1, 3);
    check("next pc", o_retire_next_pc, exp_next, cat);
    check("rd address", 32'(o_retire_rd_waddr), 32'(exp_rd), cat);
    check("rd data", o_retire_rd_wdata, exp_wd, cat);
    check("trap flag", 32'(o_retire_trap), 32'(exp_trap), cat);
    check("halt flag", 32'(o_retire_halt), 32'(exp_halt), cat);
    model_pc = exp_next;
    retired++;
    if (exp_halt) begin
      halt_seen = 1'b1;
      halt_cyc  = cyc;
    end
  endtask

  // imem model with random ready and a 1 to 4 cycle response delay
  always @(posedge i_clk) begin
    cyc          <= cyc + 1;
    i_imem_ready <= ($urandom_range(0, 3) != 0);
    i_imem_valid <= 1'b0;
    if (i_rst) begin
      resp_pending = 1'b0;
    end else begin
      if (resp_pending) begin
        if (resp_wait == 0) begin
          i_imem_valid            <= 1'b1;
          i_imem_rdata            <= resp_data;
          resp_cyc[resp_addr[9:2]] <= cyc + 1;
          resp_pending = 1'b0;
        end else begin
          resp_wait--;
        end
      end
      if (o_imem_ren && i_imem_ready) begin
        check("one outstanding request", 32'(resp_pending), 32'd0, 3);
        resp_pending = 1'b1;
        resp_wait    = $urandom_range(0, 3);
        resp_addr    = o_imem_raddr;
        resp_data    = mem_word(o_imem_raddr);
      end
    end
  end

  // the retire outputs are registered and so are settled at each edge
  always @(posedge i_clk) begin
    if (i_rst) begin
      if (rst_edges > 0) begin
        check("request during reset", 32'(o_imem_ren), 32'd0, 0);
        check("retire during reset", 32'(o_retire_valid), 32'd0, 0);
      end
      rst_edges++;
    end else if (halt_seen) begin
      check("retire after halt", 32'(o_retire_valid), 32'd0, 5);
      // by now the queue is full and fetch has gone quiet
      if (cyc - halt_cyc > 50) begin
        check("request after halt", 32'(o_imem_ren), 32'd0, 5);
      end
    end else if (o_retire_valid) begin
      retire_check();
    end
  end

  initial begin
    int waited;
    void'($urandom(32'hd656));
    for (int i = 0; i < PROG_LEN; i++) begin
      prog[i] = gen_word(i);
    end
    for (int r = 0; r < 32; r++) begin
      mregs[r] = '0;
    end
    repeat (16) @(posedge i_clk);
    i_rst <= 1'b0;
    waited = 0;
    while (!halt_seen && waited < HALT_TIMEOUT) begin
      @(posedge i_clk);
      waited++;
    end
    if (!halt_seen) begin
      $display("timeout: no ebreak retired within %0d cycles", HALT_TIMEOUT);
      timed_out = 1'b1;
    end else begin
      waited = 0;
      while (waited < HALT_WINDOW) begin
        @(posedge i_clk);
        waited++;
      end
    end
    if (retired == 0) begin
      $display("test %s: fail, no instruction retired", cat_name[0]);
    end
    for (int k = 1; k < 6; k++) begin
      $display("test %s: %s", cat_name[k], (cat_err[k] == 0 && !timed_out) ? "pass" : "fail");
    end
    $display("checks passed: %0d, failed: %0d, retired: %0d", pass_cnt, fail_cnt, retired);
    if (fail_cnt == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- files.f
hart_cfg_pkg.sv
rv_isa_pkg.sv
fetch_unit.sv
inst_queue.sv
reg_file.sv
exec_unit.sv
hart.sv
tb_hart.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_hart
FILELIST := files.f
OBJ_DIR  := obj_dir
PASS_MSG := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
